// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_load_store_unit
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= All checks passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o $(TOP)
	@out="$$(./$(OBJ_DIR)/$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// File: design/access_decoder.sv
/* Combinational load/store decode. Misaligned halfword or word accesses and
   illegal funct3 codes give a fault and no memory request */
`timescale 1ns/1ps

module access_decoder import lsu_pkg::*;
(
    input  logic [6:0]  opcode,
    input  logic [2:0]  funct3,
    input  logic [31:0] address,
    input  logic [31:0] store_data,
    output mem_req_t    req,
    output logic        fault
);

    logic [1:0] offset;
    logic       is_load;
    logic       is_store;
    logic [3:0] lane_mask;
    logic       width_ok;      // funct3 is legal for this opcode
    logic       aligned;
    logic       accept;
    mem_word_u  lane_data;

    assign offset   = address[1:0];
    assign is_load  = (opcode == opcode_load);
    assign is_store = (opcode == opcode_store);

    // Width decode into lanes, and store data copied into every matching lane
    always_comb
    begin
        lane_mask      = 4'b0000;
        width_ok       = 1'b0;
        aligned        = 1'b1;
        lane_data.word = store_data;
        case (funct3)
            f3_byte, f3_byte_u:
            begin
                lane_mask       = 4'b0001 << offset;
                width_ok        = is_load || (funct3 == f3_byte);   // No SBU
                lane_data.lanes = {4{store_data[7:0]}};
            end
            f3_half, f3_half_u:
            begin
                lane_mask      = offset[1] ? 4'b1100 : 4'b0011;
                width_ok       = is_load || (funct3 == f3_half);    // No SHU
                aligned        = ~offset[0];
                lane_data.word = {2{store_data[15:0]}};
            end
            f3_word:
            begin
                lane_mask = 4'b1111;
                width_ok  = 1'b1;
                aligned   = (offset == 2'b00);
            end
            default:
            begin
                width_ok = 1'b0;   // Codes 011, 110, 111 are unused
            end
        endcase
    end

    // Only load and store opcodes can request or fault
    assign accept = (is_load || is_store) && width_ok && aligned;
    assign fault  = (is_load || is_store) && !accept;

    assign req.read       = accept && is_load;
    assign req.write      = accept && is_store;
    assign req.byte_mask  = accept ? lane_mask : 4'b0000;
    assign req.word_index = address[mem_index_bits+1:2];
    assign req.wdata      = lane_data;

endmodule

// File: design/data_memory.sv
/* Single-port word memory with per-byte write lanes and a registered read.
   Contents are not reset and read data holds until the next read */
`timescale 1ns/1ps

module data_memory import lsu_pkg::*;
(
    input  logic      memory_done,
    input  mem_req_t  req,
    output mem_word_u rdata
);

    mem_word_u mem [mem_depth];

    // Store path goes through the byte view
    always_ff @(posedge memory_done)
    begin
        if (req.write)
        begin
            for (int lane = 0; lane < 4; lane++)
            begin
                if (req.byte_mask[lane])
                begin
                    mem[req.word_index].lanes[lane] <= req.wdata.lanes[lane];
                end
            end
        end
    end

    // Load path registers the whole word
    always_ff @(posedge memory_done)
    begin
        if (req.read)
        begin
            rdata.word <= mem[req.word_index].word;
        end
    end

    // Decoder must never issue a store that touches no lane
    assert property (@(posedge memory_done) req.write |-> req.byte_mask != 4'b0000)
        else $error("data_memory: write with empty byte mask at word %0d",
                    req.word_index);

endmodule

// File: design/load_store_unit.sv
/* Load/store unit top. Load data returns 2 edges after sampling with a
   one-cycle load_valid; faults pulse access_fault 1 edge after sampling */
`timescale 1ns/1ps

module load_store_unit import lsu_pkg::*;
(
    input  logic        memory_done,
    input  logic        reset,
    input  logic [6:0]  opcode,
    input  logic [2:0]  funct3,
    input  logic [31:0] address,
    input  logic [31:0] store_data,
    output logic [31:0] load_data,
    output logic        load_valid,
    output logic        access_fault
);

    mem_req_t    req;
    logic        dec_fault;
    mem_word_u   rdata;
    load_tag_t   tag_q;          // Travels with the memory read
    logic        read_pending;
    logic [31:0] shifted;
    logic [31:0] extended;

    access_decoder access_decoder_inst
    (
        .opcode     (opcode),
        .funct3     (funct3),
        .address    (address),
        .store_data (store_data),
        .req        (req),
        .fault      (dec_fault)
    );

    data_memory data_memory_inst
    (
        .memory_done (memory_done),
        .req         (req),
        .rdata       (rdata)
    );

    // Tag captured on the same edge as the memory read
    always_ff @(posedge memory_done)
    begin
        if (req.read)
        begin
            tag_q.funct3 <= funct3;
            tag_q.offset <= address[1:0];
        end
    end

    // Shift the addressed lane down, then extend by load type
    always_comb
    begin
        shifted = rdata.word >> {tag_q.offset, 3'b000};
        case (tag_q.funct3)
            f3_byte:   extended = {{24{shifted[7]}}, shifted[7:0]};     // LB
            f3_half:   extended = {{16{shifted[15]}}, shifted[15:0]};   // LH
            f3_byte_u: extended = {24'b0, shifted[7:0]};                // LBU
            f3_half_u: extended = {16'b0, shifted[15:0]};               // LHU
            default:   extended = shifted;                              // LW
        endcase
    end

    always_ff @(posedge memory_done)
    begin
        if (reset)
        begin
            read_pending <= 1'b0;
            load_valid   <= 1'b0;
            access_fault <= 1'b0;
            load_data    <= 32'b0;
        end
        else
        begin
            read_pending <= req.read;
            load_valid   <= read_pending;
            access_fault <= dec_fault;   // One-cycle pulse per faulting request
            if (read_pending)
            begin
                load_data <= extended;
            end
        end
    end

    // A faulting request never produces a load result one cycle later
    assert property (@(posedge memory_done) disable iff (reset)
                     access_fault |=> !load_valid)
        else $error("load_store_unit: load_valid after a faulted request");

endmodule

// File: design/lsu_pkg.sv
/* Shared codes and types for the data-memory side of an RV32I core.
   256 words of data memory; address bits above 9 are ignored, contents are not reset */
package lsu_pkg;

    // RV32I major opcodes
    localparam logic [6:0] opcode_load  = 7'b000_0011;
    localparam logic [6:0] opcode_store = 7'b010_0011;

    // Access width codes in funct3
    localparam logic [2:0] f3_byte   = 3'b000;
    localparam logic [2:0] f3_half   = 3'b001;
    localparam logic [2:0] f3_word   = 3'b010;
    localparam logic [2:0] f3_byte_u = 3'b100;
    localparam logic [2:0] f3_half_u = 3'b101;

    // Word index taken from byte address bits 9:2
    localparam int mem_index_bits = 8;
    localparam int mem_depth      = 2 ** mem_index_bits;

    // One memory word, read whole or written lane by lane
    typedef union packed {
        logic [31:0]     word;
        logic [3:0][7:0] lanes;      // Lane 0 is bits 7:0
    } mem_word_u;

    // Request from the decoder to the memory
    typedef struct packed {
        logic                      read;
        logic                      write;
        logic [3:0]                byte_mask;   // Bit i enables lane i
        logic [mem_index_bits-1:0] word_index;
        mem_word_u                 wdata;       // Store data already in its lanes
    } mem_req_t;

    // What the load extension needs once the word comes back
    typedef struct packed {
        logic [2:0] funct3;
        logic [1:0] offset;
    } load_tag_t;

endpackage

// File: filelist.f
design/lsu_pkg.sv
design/access_decoder.sv
design/data_memory.sv
design/load_store_unit.sv
tb/lsu_checker.sv
tb/tb_load_store_unit.sv

// File: tb/lsu_checker.sv
/* Byte-level reference model of the load/store unit for words 0 to 15 only.
   Requests are taken at the falling edge, half a cycle before the DUT samples them */
`timescale 1ns/1ps

module lsu_checker import lsu_pkg::*;
(
    input  logic        memory_done,
    input  logic        reset,
    input  logic [6:0]  opcode,
    input  logic [2:0]  funct3,
    input  logic [31:0] address,
    input  logic [31:0] store_data,
    input  logic [31:0] load_data,
    input  logic        load_valid,
    input  logic        access_fault,
    output int          error_count,
    output int          load_count,
    output int          fault_count
);

    logic [7:0]  model [64];         // Bytes of words 0 to 15
    logic [31:0] exp_data_q [$];
    int          exp_due_q [$];      // Cycle in which load_valid is due
    int          cycle = 0;
    int          errors = 0;
    int          loads = 0;
    int          faults = 0;
    logic        fault_now = 1'b0;   // Pulse expected in this cycle
    logic        fault_next = 1'b0;
    logic        reset_prev = 1'b0;

    assign error_count = errors;
    assign load_count  = loads;
    assign fault_count = faults;

    // RV32I width and alignment rules
    function automatic logic width_legal(input logic [2:0] f3, input logic [1:0] off,
                                         input logic is_load);
        case (f3)
            f3_byte:   return 1'b1;
            f3_half:   return (off[0] == 1'b0);
            f3_word:   return (off == 2'b00);
            f3_byte_u: return is_load;
            f3_half_u: return is_load && (off[0] == 1'b0);
            default:   return 1'b0;
        endcase
    endfunction

    function automatic logic [31:0] load_value(input logic [2:0] f3, input logic [5:0] a);
        logic [7:0] b0;
        logic [7:0] b1;
        b0 = model[a];
        b1 = model[a + 6'd1];
        case (f3)
            f3_byte:   return {{24{b0[7]}}, b0};
            f3_byte_u: return {24'b0, b0};
            f3_half:   return {{16{b1[7]}}, b1, b0};
            f3_half_u: return {16'b0, b1, b0};
            default:   return {model[a + 6'd3], model[a + 6'd2], b1, b0};
        endcase
    endfunction

    task automatic apply_store(input logic [2:0] f3, input logic [5:0] a,
                               input logic [31:0] data);
        model[a] = data[7:0];
        if (f3 != f3_byte)
            model[a + 6'd1] = data[15:8];
        if (f3 == f3_word)
        begin
            model[a + 6'd2] = data[23:16];
            model[a + 6'd3] = data[31:24];
        end
    endtask

    task automatic sample_request();
        logic [1:0] off;
        off = address[1:0];
        if (opcode == opcode_load)
        begin
            if (!width_legal(funct3, off, 1'b1))
                fault_next = 1'b1;
            else
            begin
                exp_data_q.push_back(load_value(funct3, address[5:0]));
                exp_due_q.push_back(cycle + 2);   // Read edge, then result edge
            end
        end
        else if (opcode == opcode_store)
        begin
            if (!width_legal(funct3, off, 1'b0))
                fault_next = 1'b1;             // Model left untouched
            else
                apply_store(funct3, address[5:0], store_data);
        end
    endtask

    task automatic check_reset_outputs();
        if (load_valid !== 1'b0 || access_fault !== 1'b0 || load_data !== 32'b0)
        begin
            $display("Fail at %0t: after reset load_valid %b access_fault %b load_data %h",
                     $time, load_valid, access_fault, load_data);
            errors = errors + 1;
        end
    endtask

    task automatic check_fault_output();
        if (fault_now && access_fault !== 1'b1)
        begin
            $display("Missing access_fault pulse at %0t for a faulting request", $time);
            errors = errors + 1;
        end
        else if (!fault_now && access_fault !== 1'b0)
        begin
            $display("Unexpected access_fault at %0t", $time);
            errors = errors + 1;
        end
        else if (fault_now)
            faults = faults + 1;
    endtask

    task automatic check_load_output();
        if (exp_due_q.size() > 0 && exp_due_q[0] == cycle)
        begin
            if (load_valid !== 1'b1)
            begin
                $display("Missing load_valid at %0t for a sampled load", $time);
                errors = errors + 1;
            end
            else if (load_data !== exp_data_q[0])
            begin
                $display("Fail at %0t: load_data %h, expected %h",
                         $time, load_data, exp_data_q[0]);
                errors = errors + 1;
            end
            loads = loads + 1;
            void'(exp_data_q.pop_front());
            void'(exp_due_q.pop_front());
        end
        else if (load_valid !== 1'b0)
        begin
            $display("Unexpected load_valid at %0t with no load outstanding", $time);
            errors = errors + 1;
        end
    endtask

    // Outputs here reflect the last rising edge
    always @(negedge memory_done)
    begin
        cycle      = cycle + 1;
        fault_now  = fault_next;
        fault_next = 1'b0;
        if (reset_prev)
            check_reset_outputs();
        else
        begin
            check_fault_output();
            check_load_output();
        end
        reset_prev = reset;
        if (reset)
        begin
            exp_data_q.delete();
            exp_due_q.delete();
        end
        else
            sample_request();
    end

endmodule

// File: tb/tb_load_store_unit.sv
/* Random load/store traffic on words 0 to 15 with upper address bits scrambled.
   Inputs change 1 ns after each rising edge of memory_done */
`timescale 1ns/1ps

module tb_load_store_unit import lsu_pkg::*; ();

    localparam int n_ops = 2000;   // Request cycles, first 32 included

    logic        memory_done = 1'b0;
    logic        reset;
    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [31:0] address;
    logic [31:0] store_data;
    logic [31:0] load_data;
    logic        load_valid;
    logic        access_fault;
    int          error_count;
    int          load_count;
    int          fault_count;
    int          seed = 32'h54f6_035b;
    int          ops_done = 0;

    always #4 memory_done = ~memory_done;

    load_store_unit load_store_unit_inst
    (
        .memory_done  (memory_done),
        .reset        (reset),
        .opcode       (opcode),
        .funct3       (funct3),
        .address      (address),
        .store_data   (store_data),
        .load_data    (load_data),
        .load_valid   (load_valid),
        .access_fault (access_fault)
    );

    lsu_checker lsu_checker_inst
    (
        .memory_done  (memory_done),
        .reset        (reset),
        .opcode       (opcode),
        .funct3       (funct3),
        .address      (address),
        .store_data   (store_data),
        .load_data    (load_data),
        .load_valid   (load_valid),
        .access_fault (access_fault),
        .error_count  (error_count),
        .load_count   (load_count),
        .fault_count  (fault_count)
    );

    function automatic logic [31:0] make_address(input logic [3:0] word, input logic [1:0] off);
        logic [31:0] upper;
        upper = $random(seed);
        return {upper[31:10], 4'b0000, word, off};   // Bits 31:10 are ignored
    endfunction

    function automatic logic [2:0] load_code(input logic [2:0] sel);
        case (sel)
            3'd0, 3'd5: return f3_byte;
            3'd1, 3'd6: return f3_half;
            3'd3:       return f3_byte_u;
            3'd4:       return f3_half_u;
            default:    return f3_word;
        endcase
    endfunction

    function automatic logic [1:0] aligned_offset(input logic [2:0] f3, input logic [1:0] raw);
        case (f3)
            f3_half, f3_half_u: return {raw[1], 1'b0};
            f3_word:            return 2'b00;
            default:            return raw;
        endcase
    endfunction

    task automatic drive_request(input logic [6:0] op, input logic [2:0] f3,
                                 input logic [31:0] addr, input logic [31:0] data);
        opcode     = op;
        funct3     = f3;
        address    = addr;
        store_data = data;
        ops_done   = ops_done + 1;
        @(posedge memory_done);
        #1;
    endtask

    task automatic idle_cycle();
        opcode = 7'b000_0000;
        @(posedge memory_done);
        #1;
    endtask

    task automatic legal_load(input logic [31:0] r);
        logic [2:0] f3;
        f3 = load_code(r[6:4]);
        drive_request(opcode_load, f3, make_address(r[12:9], aligned_offset(f3, r[8:7])), r);
    endtask

    task automatic legal_store(input logic [31:0] r);
        logic [2:0] f3;
        f3 = (r[5:4] == 2'd1) ? f3_half : (r[5:4] == 2'd2) ? f3_word : f3_byte;
        drive_request(opcode_store, f3, make_address(r[12:9], aligned_offset(f3, r[8:7])),
                      $random(seed));
    endtask

    task automatic random_op();
        logic [31:0] r;
        logic [31:0] r_run;
        logic [6:0]  op;
        r = $random(seed);
        if (r[3:0] < 4'd6)
            legal_load(r);
        else if (r[3:0] < 4'd11)
            legal_store(r);
        else if (r[3:0] < 4'd13)   // Any width and offset, often illegal
            drive_request(r[9] ? opcode_store : opcode_load, r[12:10],
                          make_address(r[16:13], r[18:17]), $random(seed));
        else if (r[3:0] == 4'd13)
        begin
            op = r[22:16];
            if (op == opcode_load || op == opcode_store)
                op = 7'b011_0011;
            drive_request(op, r[12:10], make_address(r[26:23], r[28:27]), $random(seed));
        end
        else
        begin
            for (int i = 0; i < 2 + r[9:8]; i++)   // Back-to-back loads
            begin
                r_run = $random(seed);
                legal_load(r_run);
            end
        end
    endtask

    initial
    begin
        reset      = 1'b1;
        opcode     = 7'b000_0000;
        funct3     = 3'b000;
        address    = 32'b0;
        store_data = 32'b0;
        repeat (2) @(posedge memory_done);
        #1;
        reset = 1'b0;
        for (int w = 0; w < 16; w++)
            drive_request(opcode_store, f3_word, make_address(w[3:0], 2'b00), $random(seed));
        for (int w = 0; w < 16; w++)
            drive_request(opcode_load, f3_word, make_address(w[3:0], 2'b00), 32'b0);
        while (ops_done < n_ops)
            random_op();
        repeat (4) idle_cycle();   // Let the last load return
        $display("Loads checked %0d, faults checked %0d, errors %0d",
                 load_count, fault_count, error_count);
        if (error_count == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

    // Watchdog
    initial
    begin
        #((n_ops + 50) * 8);
        $display("Timeout: the test did not finish in time");
        $display("Checks failed");
        $finish;
    end

endmodule
